/* seq_pkg.sv */
/*
 * Shared definitions of the vector instruction sequencer
 * Sizes of the lanes, ids, registers and unit queues
 * Register, id, length and count types
 * Operation class and functional unit enums
 * Dispatcher request, hazard vectors and PE request structs
 */
`default_nettype none

package seq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Parallel lanes
  localparam int unsigned NrLanes = 2;
  // Instruction ids in flight
  localparam int unsigned NrVInsn = 8;
  // Lanes plus load, store, slide and mask units
  localparam int unsigned NrPEs   = NrLanes + 4;
  localparam int unsigned NrVRegs = 32;

  // PE index of each unit, counted after the lanes
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;
  localparam int unsigned OffsetSlide = 2;
  localparam int unsigned OffsetMask  = 3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [4:0]         vreg_t;
  typedef logic [2:0]         vid_t;
  // One bit per instruction id
  typedef logic [NrVInsn-1:0] vinsn_mask_t;
  typedef logic [15:0]        vl_t;

  // v0 holds the mask
  localparam vreg_t VMask = 5'd0;

  typedef enum logic [2:0] {
    OP_ALU,
    OP_FPU,
    OP_MASK,
    OP_LOAD,
    OP_STORE,
    OP_SLIDE
  } op_class_e;

  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_FPU,
    UNIT_MASK,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE
  } unit_e;

  localparam int unsigned NrUnits = 6;
  // One bit per functional unit, indexed by unit_e
  typedef logic [NrUnits-1:0] unit_mask_t;

  // Queue depth per unit, in unit_e order
  localparam int unsigned QueueDepth [NrUnits] = '{4, 4, 1, 2, 2, 2};
  localparam int unsigned MaxQueueDepth = 4;
  // Must hold the value MaxQueueDepth itself
  localparam int unsigned CntWidth = $clog2(MaxQueueDepth + 1);
  typedef logic [CntWidth-1:0] cnt_t;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Request from the dispatcher
  typedef struct packed {
    op_class_e op;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd;
    logic      vm;       // 1 means unmasked
    vl_t       vl;
  } seq_req_t;

  // Ids each operand has to wait for
  typedef struct packed {
    vinsn_mask_t hz_vs1;
    vinsn_mask_t hz_vs2;
    vinsn_mask_t hz_vm;
    vinsn_mask_t hz_vd;
  } hazards_t;

  // Request broadcast to the PEs
  typedef struct packed {
    vid_t      id;
    op_class_e op;
    unit_e     unit;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd;
    logic      vm;
    vl_t       vl;
    hazards_t  hazards;
  } pe_req_t;

endpackage

`default_nettype wire

/* seq_decode.sv */
/*
 * Request decoder of the sequencer
 * Maps the operation class to its functional unit
 * Builds the mask of units the instruction occupies
 */
`timescale 1ns/10ps
`default_nettype none

module seq_decode (
  input  seq_pkg::op_class_e  op_i,
  input  logic                vm_i,
  output seq_pkg::unit_e      unit_o,
  output seq_pkg::unit_mask_t targets_o
);

  import seq_pkg::*;

  // One unit per operation class
  always_comb begin
    unit_o = UNIT_ALU;
    case (op_i)
      OP_ALU:   unit_o = UNIT_ALU;
      OP_FPU:   unit_o = UNIT_FPU;
      OP_MASK:  unit_o = UNIT_MASK;
      OP_LOAD:  unit_o = UNIT_LOAD;
      OP_STORE: unit_o = UNIT_STORE;
      OP_SLIDE: unit_o = UNIT_SLIDE;
      default:  unit_o = UNIT_ALU;
    endcase
  end

  // Own unit, plus the mask unit
  // when the mask operand is needed
  always_comb begin
    targets_o            = '0;
    targets_o[unit_o]    = 1'b1;
    targets_o[UNIT_MASK] = targets_o[UNIT_MASK] | ~vm_i;
  end

endmodule

`default_nettype wire

/* seq_hazard.sv */
/*
 * Hazard detection of the sequencer
 * Last writer and last reader of each vector register
 * RAW, WAR and WAW hazard vectors of the pending request
 */
`timescale 1ns/10ps
`default_nettype none

module seq_hazard (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  seq_pkg::seq_req_t req_i,
  input  seq_pkg::vinsn_mask_t running_i,
  input  logic              issue_i,
  input  seq_pkg::vid_t     issue_id_i,
  output seq_pkg::hazards_t hazards_o
);

  import seq_pkg::*;

  // Id of the last access and whether it still runs
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NrVRegs-1:0] rd_list_q, rd_list_d;
  vreg_access_t [NrVRegs-1:0] wr_list_q, wr_list_d;
  // Lists with retired ids dropped
  vreg_access_t [NrVRegs-1:0] rd_live, wr_live;

  ////////////////////////////////////////////////////////////
  // Live entries
  ////////////////////////////////////////////////////////////

  // An entry counts only while its id is running
  // so a reused id never sees itself as a hazard
  always_comb begin
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      rd_live[r]       = rd_list_q[r];
      rd_live[r].valid = rd_list_q[r].valid & running_i[rd_list_q[r].vid];
      wr_live[r]       = wr_list_q[r];
      wr_live[r].valid = wr_list_q[r].valid & running_i[wr_list_q[r].vid];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard vectors
  ////////////////////////////////////////////////////////////

  always_comb begin
    hazards_o = '0;

    // RAW on the sources and the mask
    if (req_i.use_vs1 && wr_live[req_i.vs1].valid)
      hazards_o.hz_vs1[wr_live[req_i.vs1].vid] = 1'b1;
    if (req_i.use_vs2 && wr_live[req_i.vs2].valid)
      hazards_o.hz_vs2[wr_live[req_i.vs2].vid] = 1'b1;
    if (!req_i.vm && wr_live[VMask].valid)
      hazards_o.hz_vm[wr_live[VMask].vid] = 1'b1;

    // WAR, every operand stream waits for the reader of vd
    if (req_i.use_vd && rd_live[req_i.vd].valid) begin
      hazards_o.hz_vs1[rd_live[req_i.vd].vid] = 1'b1;
      hazards_o.hz_vs2[rd_live[req_i.vd].vid] = 1'b1;
      hazards_o.hz_vm[rd_live[req_i.vd].vid]  = 1'b1;
    end

    // WAW
    if (req_i.use_vd && wr_live[req_i.vd].valid)
      hazards_o.hz_vd[wr_live[req_i.vd].vid] = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_list_d = rd_live;
    wr_list_d = wr_live;
    if (issue_i) begin
      // The issued id becomes the newest access
      if (req_i.use_vd)  wr_list_d[req_i.vd]  = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs1) rd_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs2) rd_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      if (!req_i.vm)     rd_list_d[VMask]     = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_list_q <= '0;
      wr_list_q <= '0;
    end else begin
      rd_list_q <= rd_list_d;
      wr_list_q <= wr_list_d;
    end
  end

endmodule

`default_nettype wire

/* seq_insn_tracker.sv */
/*
 * Instruction tracker of the sequencer
 * Per-PE table of running ids and lowest free id
 * Idle flag and global hazard table between ids
 */
`timescale 1ns/10ps
`default_nettype none

module seq_insn_tracker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  seq_pkg::unit_e       unit_i,
  input  logic                 vm_i,
  input  seq_pkg::hazards_t    hazards_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrPEs-1:0] pe_done_i,
  output seq_pkg::vid_t        free_id_o,
  output logic                 full_o,
  output seq_pkg::vinsn_mask_t running_o,
  output seq_pkg::vinsn_mask_t [seq_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                 idle_o
);

  import seq_pkg::*;

  // Bit [pe][id] set while that id runs on that PE
  vinsn_mask_t [NrPEs-1:0]   pe_running_q, pe_running_d;
  vinsn_mask_t [NrVInsn-1:0] table_d;

  // Running anywhere
  always_comb begin
    running_o = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++)
      running_o = running_o | pe_running_q[pe];
  end

  // Lowest clear id wins
  always_comb begin
    free_id_o = '0;
    for (int i = int'(NrVInsn) - 1; i >= 0; i--)
      if (!running_o[i]) free_id_o = vid_t'(i);
  end

  assign full_o = &running_o;

  ////////////////////////////////////////////////////////////
  // Running table and hazard table
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Done bits retire ids per PE
    for (int unsigned pe = 0; pe < NrPEs; pe++)
      pe_running_d[pe] = pe_running_q[pe] & ~pe_done_i[pe];

    // Rows of retired ids clear, columns of retired ids drop
    for (int unsigned id = 0; id < NrVInsn; id++)
      table_d[id] = running_o[id] ? (hazard_table_o[id] & running_o) : '0;

    if (issue_i) begin
      case (unit_i)
        UNIT_LOAD:  pe_running_d[NrLanes + OffsetLoad][free_id_o]  = 1'b1;
        UNIT_STORE: pe_running_d[NrLanes + OffsetStore][free_id_o] = 1'b1;
        UNIT_SLIDE: pe_running_d[NrLanes + OffsetSlide][free_id_o] = 1'b1;
        UNIT_MASK:  pe_running_d[NrLanes + OffsetMask][free_id_o]  = 1'b1;
        // ALU and FPU work on every lane
        default: begin
          for (int unsigned l = 0; l < NrLanes; l++)
            pe_running_d[l][free_id_o] = 1'b1;
        end
      endcase
      // Mask operand comes through the mask unit
      if (!vm_i) pe_running_d[NrLanes + OffsetMask][free_id_o] = 1'b1;

      table_d[free_id_o] = hazards_i.hz_vs1 | hazards_i.hz_vs2 |
                           hazards_i.hz_vm  | hazards_i.hz_vd;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q   <= '0;
      hazard_table_o <= '0;
      idle_o         <= 1'b1;
    end else begin
      pe_running_q   <= pe_running_d;
      hazard_table_o <= table_d;
      // Follows the running mask by one cycle
      idle_o         <= ~|running_o;
    end
  end

endmodule

`default_nettype wire

/* seq_unit_credits.sv */
/*
 * Queue credits of the sequencer
 * One occupancy counter per functional unit
 * Issue permission for the targeted units
 */
`timescale 1ns/10ps
`default_nettype none

module seq_unit_credits (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  seq_pkg::unit_mask_t  targets_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrPEs-1:0] pe_done_i,
  input  logic                 alu_done_i,
  input  logic                 fpu_done_i,
  output logic                 unit_ok_o
);

  import seq_pkg::*;

  unit_mask_t unit_done;
  unit_mask_t unit_ready;

  // ALU and FPU report once per instruction from lane 0
  // the other units report by their id bits
  assign unit_done[UNIT_ALU]   = alu_done_i;
  assign unit_done[UNIT_FPU]   = fpu_done_i;
  assign unit_done[UNIT_MASK]  = |pe_done_i[NrLanes + OffsetMask];
  assign unit_done[UNIT_LOAD]  = |pe_done_i[NrLanes + OffsetLoad];
  assign unit_done[UNIT_STORE] = |pe_done_i[NrLanes + OffsetStore];
  assign unit_done[UNIT_SLIDE] = |pe_done_i[NrLanes + OffsetSlide];

  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    localparam cnt_t Depth = cnt_t'(QueueDepth[u]);

    cnt_t cnt_q;
    logic cnt_up;

    assign cnt_up        = issue_i & targets_i[u];
    // Room for one more
    assign unit_ready[u] = cnt_q < Depth;

    // Issue and done in the same cycle cancel
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !unit_done[u]) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (!cnt_up && unit_done[u]) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  // Units not targeted never block
  assign unit_ok_o = &(~targets_i | unit_ready);

endmodule

`default_nettype wire

/* seq_issue.sv */
/*
 * Issue stage of the sequencer
 * Issue decision and request handshake
 * Registered PE request with hold under lane back-pressure
 */
`timescale 1ns/10ps
`default_nettype none

module seq_issue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  seq_pkg::seq_req_t req_i,
  input  logic              req_valid_i,
  input  seq_pkg::unit_e    unit_i,
  input  seq_pkg::hazards_t hazards_i,
  input  seq_pkg::vid_t     free_id_i,
  input  logic              full_i,
  input  logic              unit_ok_i,
  input  logic [seq_pkg::NrPEs-1:0] pe_req_ready_i,
  output logic              req_ready_o,
  output logic              issue_o,
  output seq_pkg::vid_t     issue_id_o,
  output seq_pkg::pe_req_t  pe_req_o,
  output logic              pe_req_valid_o
);

  import seq_pkg::*;

  logic lanes_ready;
  logic hold;
  logic no_operands;
  logic stall_hazard;

  // Only the lanes gate the request
  assign lanes_ready = &pe_req_ready_i[NrLanes-1:0];
  assign hold        = pe_req_valid_o & ~lanes_ready;

  // Without source operands nothing waits on chaining
  // so any hazard has to resolve before issue
  assign no_operands  = ~req_i.use_vs1 & ~req_i.use_vs2 & req_i.vm;
  assign stall_hazard = no_operands & (|hazards_i);

  assign req_ready_o = ~hold & ~full_i & unit_ok_i & ~stall_hazard;
  assign issue_o     = req_valid_i & req_ready_o;
  assign issue_id_o  = free_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (!hold) begin
      pe_req_valid_o <= issue_o;
    end
  end

  // Loaded only on issue, so it holds while stalled
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_req_o <= '{
        id:      free_id_i,
        op:      req_i.op,
        unit:    unit_i,
        vs1:     req_i.vs1,
        vs2:     req_i.vs2,
        vd:      req_i.vd,
        use_vs1: req_i.use_vs1,
        use_vs2: req_i.use_vs2,
        use_vd:  req_i.use_vd,
        vm:      req_i.vm,
        vl:      req_i.vl,
        hazards: hazards_i
      };
    end
  end

endmodule

`default_nettype wire

/* vinsn_sequencer.sv */
/*
 * Vector instruction sequencer top level
 * Decoder, hazard lists, id tracker, unit credits and issue stage
 */
`timescale 1ns/10ps
`default_nettype none

module vinsn_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  seq_pkg::seq_req_t    req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output seq_pkg::pe_req_t     pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic [seq_pkg::NrPEs-1:0] pe_req_ready_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrPEs-1:0] pe_done_i,
  input  logic                 alu_done_i,
  input  logic                 fpu_done_i,
  output seq_pkg::vinsn_mask_t vinsn_running_o,
  output seq_pkg::vinsn_mask_t [seq_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                 idle_o
);

  import seq_pkg::*;

  unit_e      unit;
  unit_mask_t targets;
  hazards_t   hazards;
  vid_t       free_id;
  vid_t       issue_id;
  logic       full;
  logic       unit_ok;
  logic       issue;

  // Input side
  seq_decode u_decode (
    .op_i      (req_i.op),
    .vm_i      (req_i.vm),
    .unit_o    (unit),
    .targets_o (targets)
  );

  // Processing part
  seq_hazard u_hazard (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .running_i  (vinsn_running_o),
    .issue_i    (issue),
    .issue_id_i (issue_id),
    .hazards_o  (hazards)
  );

  seq_insn_tracker u_insn_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue),
    .unit_i         (unit),
    .vm_i           (req_i.vm),
    .hazards_i      (hazards),
    .pe_done_i      (pe_done_i),
    .free_id_o      (free_id),
    .full_o         (full),
    .running_o      (vinsn_running_o),
    .hazard_table_o (hazard_table_o),
    .idle_o         (idle_o)
  );

  seq_unit_credits u_unit_credits (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .targets_i  (targets),
    .pe_done_i  (pe_done_i),
    .alu_done_i (alu_done_i),
    .fpu_done_i (fpu_done_i),
    .unit_ok_o  (unit_ok)
  );

  // Output side
  seq_issue u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .unit_i         (unit),
    .hazards_i      (hazards),
    .free_id_i      (free_id),
    .full_i         (full),
    .unit_ok_i      (unit_ok),
    .pe_req_ready_i (pe_req_ready_i),
    .req_ready_o    (req_ready_o),
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o)
  );

endmodule

`default_nettype wire

/* tb_vinsn_sequencer.sv */
/*
 * Testbench of the vector instruction sequencer
 * Clock, reset, LCG, request driver and PE done model
 * Reference model of ids, units and queue counts
 * Six directed tests, watchdog and final report
 */
`timescale 1ns/10ps
`default_nettype none

module tb_vinsn_sequencer;

  import seq_pkg::*;

  localparam int NrTests = 6;
  localparam int ClkPeriod = 8;

  logic clk_i;
  logic rst_ni;
  seq_req_t req_i;
  logic req_valid_i;
  logic req_ready_o;
  pe_req_t pe_req_o;
  logic pe_req_valid_o;
  logic [NrPEs-1:0] pe_req_ready_i;
  vinsn_mask_t [NrPEs-1:0] pe_done_i;
  logic alu_done_i;
  logic fpu_done_i;
  vinsn_mask_t vinsn_running_o;
  vinsn_mask_t [NrVInsn-1:0] hazard_table_o;
  logic idle_o;

  // Reference model state
  vinsn_mask_t model_run;
  unit_e unit_of [NrVInsn];
  logic masked_of [NrVInsn];
  int unit_cnt [NrUnits];
  int unsigned lcg_state = 38162;
  int errors = 0;
  int failed_tests = 0;

  vinsn_sequencer u_vinsn_sequencer (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Ends a hung run after 2000 cycles per test
  initial begin
    #(NrTests * 2000 * ClkPeriod);
    $display("Watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  // Held request must not move under lane back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_o && !(&pe_req_ready_i[NrLanes-1:0]))
      |=> (pe_req_valid_o && $stable(pe_req_o)))
  else begin
    $display("** Error @%0t: PE request changed while held", $time);
    errors++;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  function automatic unit_e unit_for_op(op_class_e op);
    case (op)
      OP_FPU:   return UNIT_FPU;
      OP_MASK:  return UNIT_MASK;
      OP_LOAD:  return UNIT_LOAD;
      OP_STORE: return UNIT_STORE;
      OP_SLIDE: return UNIT_SLIDE;
      default:  return UNIT_ALU;
    endcase
  endfunction

  function automatic seq_req_t make_req(op_class_e op, vreg_t vs1, logic use_vs1,
                                        vreg_t vd, logic use_vd);
    seq_req_t r;
    r = '0;
    r.op = op;
    r.vs1 = vs1;
    r.use_vs1 = use_vs1;
    r.vd = vd;
    r.use_vd = use_vd;
    r.vm = 1'b1;
    r.vl = 16'd64;
    return r;
  endfunction

  function automatic vid_t lowest_free();
    for (int i = 0; i < NrVInsn; i++)
      if (!model_run[i]) return vid_t'(i);
    return '0;
  endfunction

  task automatic check(input logic cond, input string msg);
    assert (cond) else begin
      $display("** Error @%0t: %s", $time, msg);
      errors++;
    end
  endtask

  // Drives one request from the current falling edge
  // and waits until it reaches the PEs
  task automatic send(input seq_req_t r, output vid_t id);
    vid_t exp_id;
    unit_e u;
    req_i = r;
    req_valid_i = 1'b1;
    #1;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    exp_id = lowest_free();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    id = pe_req_o.id;
    u = unit_for_op(r.op);
    check(pe_req_valid_o, "PE request not valid one cycle after acceptance");
    check(id == exp_id, $sformatf("id %0d issued, lowest free is %0d", id, exp_id));
    check(pe_req_o.unit == u && pe_req_o.op == r.op &&
          pe_req_o.vs1 == r.vs1 && pe_req_o.vs2 == r.vs2 &&
          pe_req_o.vd == r.vd && pe_req_o.vl == r.vl &&
          {pe_req_o.use_vs1, pe_req_o.use_vs2, pe_req_o.use_vd, pe_req_o.vm} ==
          {r.use_vs1, r.use_vs2, r.use_vd, r.vm}, "PE request fields wrong");
    model_run[id] = 1'b1;
    unit_of[id] = u;
    masked_of[id] = ~r.vm;
    unit_cnt[u]++;
    check(unit_cnt[u] <= int'(QueueDepth[u]), "unit queue depth exceeded");
    check(vinsn_running_o == model_run, "running mask differs from model after issue");
  endtask

  // Pulses the done bits of one id on the PEs that run it
  task automatic retire(input int id);
    vinsn_mask_t b;
    b = vinsn_mask_t'(1) << id;
    @(negedge clk_i);
    case (unit_of[id])
      UNIT_LOAD:  pe_done_i[NrLanes + OffsetLoad] = b;
      UNIT_STORE: pe_done_i[NrLanes + OffsetStore] = b;
      UNIT_SLIDE: pe_done_i[NrLanes + OffsetSlide] = b;
      UNIT_MASK:  pe_done_i[NrLanes + OffsetMask] = b;
      default: begin
        for (int l = 0; l < NrLanes; l++) pe_done_i[l] = b;
        if (unit_of[id] == UNIT_FPU) fpu_done_i = 1'b1;
        else alu_done_i = 1'b1;
      end
    endcase
    if (masked_of[id]) pe_done_i[NrLanes + OffsetMask] |= b;
    @(negedge clk_i);
    pe_done_i = '0;
    alu_done_i = 1'b0;
    fpu_done_i = 1'b0;
    model_run[id] = 1'b0;
    unit_cnt[unit_of[id]]--;
    check(vinsn_running_o == model_run, "running mask differs from model after done");
  endtask

  task automatic retire_all();
    while (|model_run) begin
      int k;
      k = lcg_next() % NrVInsn;
      if (model_run[k]) retire(k);
    end
    repeat (3) @(negedge clk_i);
  endtask

  // Holds the pending request and expects it blocked
  task automatic expect_blocked(input seq_req_t r, input int cycles, input string msg);
    @(negedge clk_i);
    req_i = r;
    req_valid_i = 1'b1;
    repeat (cycles) begin
      #1;
      check(!req_ready_o, msg);
      @(negedge clk_i);
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: FAILED", name);
      failed_tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    vid_t a, b, c;
    pe_req_t held;
    int e;
    rst_ni = 1'b0;
    req_i = '0;
    req_valid_i = 1'b0;
    pe_req_ready_i = '1;
    pe_done_i = '0;
    alu_done_i = 1'b0;
    fpu_done_i = 1'b0;
    model_run = '0;
    foreach (unit_cnt[u]) unit_cnt[u] = 0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    e = errors;
    check(idle_o && !pe_req_valid_o, "idle or valid wrong after reset");
    check(hazard_table_o == '0 && vinsn_running_o == '0, "state not clear after reset");
    report("reset", e);

    // Four ALU and four FPU fill every id
    e = errors;
    for (int i = 0; i < NrVInsn; i++)
      send(make_req(op_class_e'(i < 4 ? OP_ALU : OP_FPU), '0, 1'b0,
                    vreg_t'(8 + i), 1'b1), a);
    expect_blocked(make_req(OP_LOAD, '0, 1'b0, 5'd20, 1'b1), 5, "ready while all ids run");
    c = vid_t'(lcg_next() % NrVInsn);
    retire(c);
    send(make_req(OP_LOAD, '0, 1'b0, 5'd20, 1'b1), a);
    check(a == c, "freed id not reused");
    retire_all();
    report("id allocation", e);

    e = errors;
    send(make_req(OP_LOAD, '0, 1'b0, 5'd3, 1'b1), a);
    send(make_req(OP_ALU, 5'd3, 1'b1, 5'd4, 1'b1), b);
    check(pe_req_o.hazards.hz_vs1 == vinsn_mask_t'(1) << a, "RAW vector wrong");
    check(hazard_table_o[b] == vinsn_mask_t'(1) << a, "RAW table row wrong");
    retire_all();
    report("RAW hazard", e);

    e = errors;
    send(make_req(OP_ALU, 5'd6, 1'b1, 5'd7, 1'b1), a);
    send(make_req(OP_ALU, 5'd9, 1'b1, 5'd6, 1'b1), b);
    check(pe_req_o.hazards.hz_vs1 == vinsn_mask_t'(1) << a &&
          pe_req_o.hazards.hz_vs2 == vinsn_mask_t'(1) << a &&
          pe_req_o.hazards.hz_vm == vinsn_mask_t'(1) << a, "WAR vectors wrong");
    expect_blocked(make_req(OP_LOAD, '0, 1'b0, 5'd6, 1'b1), 4, "operand-less write not stalled");
    retire(a);
    repeat (2) @(negedge clk_i);
    check(hazard_table_o[b] == '0, "table row keeps a retired id");
    expect_blocked(make_req(OP_LOAD, '0, 1'b0, 5'd6, 1'b1), 3, "stall left before writer done");
    retire(b);
    send(make_req(OP_LOAD, '0, 1'b0, 5'd6, 1'b1), c);
    retire_all();
    check(hazard_table_o == '0 && idle_o, "table or idle not clear after retire");
    report("WAR, WAW and stall", e);

    e = errors;
    send(make_req(OP_MASK, '0, 1'b0, 5'd10, 1'b1), a);
    expect_blocked(make_req(OP_MASK, '0, 1'b0, 5'd11, 1'b1), 4, "mask unit over depth");
    retire(a);
    send(make_req(OP_MASK, '0, 1'b0, 5'd11, 1'b1), b);
    retire_all();
    report("queue credits", e);

    e = errors;
    @(negedge clk_i);
    pe_req_ready_i[0] = 1'b0;
    send(make_req(OP_ALU, '0, 1'b0, 5'd12, 1'b1), a);
    held = pe_req_o;
    expect_blocked(make_req(OP_ALU, '0, 1'b0, 5'd13, 1'b1), 4, "ready under back-pressure");
    check(pe_req_valid_o && pe_req_o == held, "held PE request changed");
    pe_req_ready_i[0] = 1'b1;
    send(make_req(OP_ALU, '0, 1'b0, 5'd13, 1'b1), b);
    check(b != a && pe_req_o.vd == 5'd13, "next request did not follow");
    retire_all();
    report("back-pressure", e);

    $display("Tests run %0d, failures %0d, check errors %0d",
             NrTests, failed_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
seq_pkg.sv
seq_decode.sv
seq_hazard.sv
seq_insn_tracker.sv
seq_unit_credits.sv
seq_issue.sv
vinsn_sequencer.sv
tb_vinsn_sequencer.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_vinsn_sequencer
FILELIST  ?= tb.f
LOG       ?= sim.log
FAIL_MSG  := tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
